// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := corr_tb
FLIST     := vlog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and look for the pass line"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/corr_tb.sv ====
`timescale 1ns/100ps
module corr_tb import corr_pkg::*; ();

   localparam int    NANT       = 4;
   localparam int    T_CLK      = 20;                 // Clock period in ns
   localparam int    T_DRIVE    = 2;                  // Input skew after the rising edge
   localparam int    WAIT_MAX   = 64;                 // Cycles allowed for one switch_o pulse
   localparam int    LINE_CYC   = 200;                // Watchdog budget per trace line
   localparam string TRACE_FILE = "bench/corr_trace.txt";

   logic             clk_i;
   logic             sw_d;
   logic             enable_i;
   acc_t             blocksize_i;
   logic             strobe_i;
   logic [NANT-1:0]  antenna_i;
   logic             rd_stb_i;
   logic [ADR_W-1:0] adr_i;
   logic             ack_o;
   acc_t             dat_o;
   logic             switch_o;

   string       lines [$];                            // Command lines without comments
   int          errors;
   int          test_errors;                          // Errors in the running test
   int          checks;
   int          tests;
   int          tests_failed;
   longint      limit_ns;

   tb_clock #(.HALF(T_CLK / 2), .RST_CYCLES(5)) u_clk (.clk_o(clk_i), .sw_d_o(sw_d));

   corr_top #(.NANT(NANT)) u_dut (.*);

   // ----------------------------------------
   // Stimulus steps
   // ----------------------------------------
   task automatic next_cycle();
      @(posedge clk_i);
      #(T_DRIVE);
      strobe_i = 1'b0;                                // Strobes last one cycle
      rd_stb_i = 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic send_sample(input logic en, input logic [NANT-1:0] ant);
      next_cycle();
      enable_i  = en;                                 // Level held until the next sample
      antenna_i = ant;
      strobe_i  = 1'b1;
   endtask

   task automatic count_error();
      errors++;
      test_errors++;
   endtask

   // ----------------------------------------
   // Compare tasks
   // ----------------------------------------
   task automatic check_acc(input string sig, input acc_t exp, input acc_t got);
      checks++;
      if (got !== exp) begin
         $display("[FAIL] %0d ns %s expected %0d got %0d", $time, sig, exp, got);
         count_error();
      end
   endtask

   task automatic check_vis(input string sig, input vis_t exp, input vis_t got);
      checks++;
      if (got !== exp) begin
         $display("[FAIL] %0d ns %s expected cos %0d sin %0d got cos %0d sin %0d",
                  $time, sig, exp.cos, exp.sin, got.cos, got.sin);
         count_error();
      end
   endtask

   task automatic check_ack(input logic [ADR_W-1:0] adr);
      checks++;
      if (ack_o !== 1'b1) begin
         $display("ERROR at %0d ns: read of address %h was not acknowledged", $time, adr);
         count_error();
      end
   endtask

   // Ack and data belong to the cycle after the read strobe
   task automatic read_word(input logic [ADR_W-1:0] adr, output acc_t word);
      next_cycle();
      rd_stb_i = 1'b1;
      adr_i    = adr;
      next_cycle();
      check_ack(adr);
      word = dat_o;
   endtask

   task automatic wait_switch();
      int n;
      n = 1;
      next_cycle();
      while (switch_o !== 1'b1 && n < WAIT_MAX) begin
         next_cycle();
         n++;
      end
      if (switch_o !== 1'b1) begin
         $display("ERROR at %0d ns: switch_o did not pulse within %0d cycles", $time, WAIT_MAX);
         count_error();
      end
   endtask

   function automatic string word_name(input logic [ADR_W-1:0] adr);
      case (adr[7:6])
         DEV_ONES: return $sformatf("ones[%0d]", adr[5:0]);
         DEV_STAT: return "status";
         default:  return $sformatf("dat_o@%h", adr);  // Unmapped device
      endcase
   endfunction

   task automatic end_test(input string name);
      tests++;
      if (test_errors == 0) begin
         $display("test %0d %s: ok", tests, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests, name, test_errors);
      end
      test_errors = 0;
   endtask

   // ----------------------------------------
   // Trace handling
   // ----------------------------------------
   task automatic load_trace(output bit ok);
      int    fd;
      string line;
      fd = $fopen(TRACE_FILE, "r");
      ok = (fd != 0);
      if (ok) begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
               lines.push_back(line);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic run_line(input string line);
      byte              cmd;
      logic             en;
      logic [NANT-1:0]  ant;
      logic [ADR_W-1:0] adr;
      acc_t             val_a;
      acc_t             val_b;
      acc_t             word;
      vis_t             exp_v;
      vis_t             got_v;
      string            name;
      cmd = line.getc(0);
      case (cmd)
         "S": begin
            void'($sscanf(line, "S %h %h", en, ant));
            send_sample(en, ant);
         end
         "N": begin
            void'($sscanf(line, "N %d", val_a));
            idle(int'(val_a) + int'($urandom % 3));   // Gap varies but counts do not
         end
         "B": begin
            void'($sscanf(line, "B %h", val_a));
            next_cycle();
            blocksize_i = val_a;
         end
         "W": wait_switch();
         "R": begin
            void'($sscanf(line, "R %h %h %h", adr, val_a, val_b));
            if (adr[7:6] == DEV_VIS) begin             // Pair read takes cos then sin
               read_word({adr[7:1], 1'b0}, word);
               got_v.cos = word;
               read_word({adr[7:1], 1'b1}, word);
               got_v.sin = word;
               exp_v.cos = val_a;
               exp_v.sin = val_b;
               check_vis($sformatf("vis[%0d]", adr[5:1]), exp_v, got_v);
            end else begin
               read_word(adr, word);
               check_acc(word_name(adr), val_a, word);
            end
         end
         "T": begin
            void'($sscanf(line, "T %s", name));
            end_test(name);
         end
         default: begin
            $display("ERROR: unknown trace command in line: %s", line);
            count_error();
         end
      endcase
   endtask

   // ----------------------------------------
   // Main sequence and watchdog
   // ----------------------------------------
   initial begin : main
      bit ok;
      enable_i     = 1'b0;
      blocksize_i  = '0;
      strobe_i     = 1'b0;
      antenna_i    = '0;
      rd_stb_i     = 1'b0;
      adr_i        = '0;
      errors       = 0;
      test_errors  = 0;
      checks       = 0;
      tests        = 0;
      tests_failed = 0;
      void'($urandom(32'hd0aa));                      // Only the idle gaps draw from it
      load_trace(ok);
      if (!ok) begin
         $display("ERROR: cannot open %s", TRACE_FILE);
         errors++;
      end else begin
         limit_ns = longint'(lines.size()) * LINE_CYC * T_CLK;
         @(negedge sw_d);
         foreach (lines[i]) run_line(lines[i]);
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, tests_failed, checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   initial begin : watchdog
      wait (limit_ns != 0);
      #(limit_ns);
      $display("ERROR: watchdog expired after %0d ns, trace did not finish", limit_ns);
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== bench/corr_trace.txt ====
# Commands: S enable antenna | N idle | B blocksize | W | R adr expected [sin] | T name
# Hex values, N count decimal; R to device 0 reads cos and sin of the pair at adr
B 3
S 1 5
N 1
S 1 3
S 1 6
N 2
S 1 F
S 1 9
W
R 40 3
R 41 3
R 42 2
R 43 2
R 80 1
T arming
R 00 2 2
R 02 1 4
R 04 3 2
R 06 3 2
R 08 1 0
R 0A 2 1
T visibilities
S 1 A
S 1 C
S 1 0
S 1 7
S 1 E
S 1 1
S 1 B
S 1 5
W
R 80 3
R 40 3
R 41 2
R 00 1 2
R 04 1 3
R 08 4 0
T back_to_back
S 1 F
S 1 0
S 0 0
N 3
R 02 1 1
R 80 0
S 1 6
S 1 9
S 1 3
S 1 D
S 1 8
W
R 40 3
R 41 1
R 80 1
R 08 0 3
T clear
R C0 0
R 0C 0 0
R 44 0
T read_decode

// ==== bench/tb_clock.sv ====
`timescale 1ns/100ps
module tb_clock #(
   parameter int HALF       = 10,              // Half period in ns
   parameter int RST_CYCLES = 5                // Reset length in clock cycles
) (
   output logic clk_o,
   output logic sw_d_o
);

   initial begin
      clk_o = 1'b0;
      forever #(HALF) clk_o = ~clk_o;
   end

   // Reset covers whole cycles, released just past an edge
   initial begin
      sw_d_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      #1 sw_d_o = 1'b0;
   end

endmodule

// ==== hw/corr_ctrl.sv ====
`timescale 1ns/100ps
module corr_ctrl import corr_pkg::*; (
   input  logic             clk_i,
   input  logic             sw_d,
   input  logic             enable_i,
   input  acc_t             blocksize_i,       // Block length minus one
   input  logic             strobe_i,
   input  samp_t            samp_i,            // Only valid is used here
   input  logic             rd_stb_i,
   input  logic [ADR_W-1:0] adr_i,
   input  vis_t             vis_rd_i,          // Entry from visibility bank
   input  acc_t             ones_rd_i,         // Entry from ones bank
   output logic             active_o,
   output bank_ctl_t        bank_ctl_o,
   output logic [5:0]       rd_idx_o,
   output logic             ack_o,
   output acc_t             dat_o,
   output logic             switch_o
);

   // ----------------------------------------
   // Block sequencing
   // ----------------------------------------
   acc_t blk_q;                                // Counted samples in this block
   acc_t blocks_q;                             // Completed blocks, status word
   logic wrap;
   logic swap_d;

   assign wrap   = (blk_q == blocksize_i);
   // Enable sampled here too, so swap and clear never meet
   assign swap_d = enable_i && !bank_ctl_o.clear && samp_i.valid && wrap;

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         active_o   <= 1'b0;
         bank_ctl_o <= '0;
         switch_o   <= 1'b0;
         blk_q      <= '0;
         blocks_q   <= '0;
      end else begin
         if (!enable_i) active_o <= 1'b0;               // Disarm at once
         else if (strobe_i) active_o <= 1'b1;           // Arming strobe, not counted
         bank_ctl_o.clear <= !enable_i;
         bank_ctl_o.swap  <= swap_d;
         switch_o         <= bank_ctl_o.swap;           // Bank holds the block by now
         if (bank_ctl_o.clear) begin
            blk_q    <= '0;
            blocks_q <= '0;
         end else begin
            if (samp_i.valid) blk_q <= wrap ? '0 : blk_q + 1'b1;
            if (bank_ctl_o.swap) blocks_q <= blocks_q + 1'b1;
         end
      end
   end

   // ----------------------------------------
   // Read decode
   // ----------------------------------------
   logic [1:0] dev;
   acc_t       rd_word;

   assign dev = adr_i[7:6];

   always_comb begin
      // Pair index sits above the cos/sin bit
      rd_idx_o = (dev == DEV_VIS) ? {1'b0, adr_i[5:1]} : adr_i[5:0];
      case (dev)
         DEV_VIS:  rd_word = adr_i[0] ? vis_rd_i.sin : vis_rd_i.cos;
         DEV_ONES: rd_word = ones_rd_i;
         DEV_STAT: rd_word = blocks_q;
         default:  rd_word = '0;                         // Unmapped device
      endcase
   end

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) ack_o <= 1'b0;
      else ack_o <= rd_stb_i;                            // Ack on the next edge
   end

   always_ff @(posedge clk_i) begin
      if (rd_stb_i) dat_o <= rd_word;
   end

   a_swap_not_clear: assert property (
      @(posedge clk_i) disable iff (sw_d) !(bank_ctl_o.swap && bank_ctl_o.clear)
   ) else $error("swap and clear high together");

   a_ack_after_stb: assert property (
      @(posedge clk_i) disable iff (sw_d) ack_o |-> $past(rd_stb_i)
   ) else $error("ack without a read strobe");

endmodule

// ==== hw/corr_pkg.sv ====
package corr_pkg;

   // ----------------------------------------
   // Widths
   // ----------------------------------------
   localparam int ACC_W    = 32;              // Accumulator and bus data width
   localparam int ADR_W    = 8;               // Bus address width
   localparam int NANT_MAX = 8;               // Widest antenna vector in samp_t

   // Device select, address bits 7..6
   localparam logic [1:0] DEV_VIS  = 2'd0;    // Visibility bank
   localparam logic [1:0] DEV_ONES = 2'd1;    // Ones bank
   localparam logic [1:0] DEV_STAT = 2'd2;    // Completed-block count

   // ----------------------------------------
   // Types
   // ----------------------------------------
   typedef logic [ACC_W-1:0] acc_t;

   typedef struct packed {
      acc_t cos;                              // Real against real agreements
      acc_t sin;                              // Real against imaginary agreements
   } vis_t;

   typedef struct packed {
      logic                valid;             // Counted sample this cycle
      logic [NANT_MAX-1:0] re;                // Current sample, one bit per antenna
      logic [NANT_MAX-1:0] im;                // Previous sample stands in for imaginary
      logic                last;              // Reserved, always zero
   } samp_t;

   typedef struct packed {
      logic swap;                             // Block done, banks capture
      logic clear;                            // Acquisition off, counts dropped
   } bank_ctl_t;

   // Pairs (a,b), a < b, in row order
   function automatic int npairs(int n);
      return n * (n - 1) / 2;
   endfunction

   function automatic int pair_idx(int a, int b, int n);
      return a * n - a * (a + 1) / 2 + (b - a - 1);
   endfunction

   // Next accumulator value; a swap restarts the block with this cycle's hit
   function automatic acc_t acc_next(acc_t acc, logic valid, logic hit, bank_ctl_t ctl);
      acc_t inc;
      inc = (valid && hit) ? acc_t'(1) : '0;
      if (ctl.clear) return '0;
      if (ctl.swap) return inc;
      return acc + inc;
   endfunction

endpackage

// ==== hw/corr_top.sv ====
`timescale 1ns/100ps
module corr_top import corr_pkg::*; #(
   parameter int NANT = 8                      // Antenna count, at most NANT_MAX
) (
   input  logic             clk_i,
   input  logic             sw_d,
   input  logic             enable_i,          // Acquisition on, a level
   input  acc_t             blocksize_i,       // Block length minus one
   input  logic             strobe_i,          // antenna_i holds a sample
   input  logic [NANT-1:0]  antenna_i,         // Real bit per antenna
   input  logic             rd_stb_i,          // One-cycle read request
   input  logic [ADR_W-1:0] adr_i,
   output logic             ack_o,
   output acc_t             dat_o,
   output logic             switch_o           // New block readable
);

   localparam int NPAIR = npairs(NANT);

   logic       active;
   samp_t      samp;
   bank_ctl_t  bank_ctl;
   logic [5:0] rd_idx;
   vis_t       vis_live [NPAIR];               // Running visibilities
   acc_t       ones_live [NANT];               // Running ones counts
   vis_t       vis_rd;
   acc_t       ones_rd;

   corr_ctrl u_ctrl (
      .clk_i, .sw_d, .enable_i, .blocksize_i, .strobe_i,
      .samp_i    (samp),
      .rd_stb_i, .adr_i,
      .vis_rd_i  (vis_rd),
      .ones_rd_i (ones_rd),
      .active_o  (active),
      .bank_ctl_o(bank_ctl),
      .rd_idx_o  (rd_idx),
      .ack_o, .dat_o, .switch_o
   );

   // Sample pairing, current real with previous as imaginary
   quad_delay #(.NANT(NANT)) u_quad (
      .clk_i, .sw_d, .strobe_i, .antenna_i,
      .active_i(active),
      .samp_o  (samp)
   );

   vis_accum #(.NANT(NANT)) u_vis (
      .clk_i, .sw_d,
      .samp_i    (samp),
      .bank_ctl_i(bank_ctl),
      .vis_o     (vis_live)
   );

   ones_accum #(.NANT(NANT)) u_ones (
      .clk_i, .sw_d,
      .samp_i    (samp),
      .bank_ctl_i(bank_ctl),
      .ones_o    (ones_live)
   );

   // Frozen copies for the readout bus
   read_bank #(.entry_t(vis_t), .DEPTH(NPAIR)) u_vis_bank (
      .clk_i, .sw_d,
      .bank_ctl_i(bank_ctl),
      .live_i    (vis_live),
      .rd_idx_i  (rd_idx),
      .rd_o      (vis_rd)
   );

   read_bank #(.entry_t(acc_t), .DEPTH(NANT)) u_ones_bank (
      .clk_i, .sw_d,
      .bank_ctl_i(bank_ctl),
      .live_i    (ones_live),
      .rd_idx_i  (rd_idx),
      .rd_o      (ones_rd)
   );

endmodule

// ==== hw/ones_accum.sv ====
`timescale 1ns/100ps
module ones_accum import corr_pkg::*; #(
   parameter int NANT = 8
) (
   input  logic      clk_i,
   input  logic      sw_d,
   input  samp_t     samp_i,
   input  bank_ctl_t bank_ctl_i,
   output acc_t      ones_o [NANT]             // Ones per antenna, this block
);

   // Means of the one-bit streams, since antenna gains are unknown
   for (genvar gi = 0; gi < NANT; gi++) begin : g_ant
      always_ff @(posedge clk_i or posedge sw_d) begin
         if (sw_d) begin
            ones_o[gi] <= '0;
         end else begin
            ones_o[gi] <= acc_next(ones_o[gi], samp_i.valid, samp_i.re[gi], bank_ctl_i);
         end
      end
   end

endmodule

// ==== hw/quad_delay.sv ====
`timescale 1ns/100ps
module quad_delay import corr_pkg::*; #(
   parameter int NANT = 8
) (
   input  logic            clk_i,
   input  logic            sw_d,
   input  logic            strobe_i,
   input  logic [NANT-1:0] antenna_i,
   input  logic            active_i,           // Armed by an earlier strobe
   output samp_t           samp_o
);

   // Delayed copy of the real bit, a crude Hilbert transform
   logic [NANT-1:0] prev_q;
   logic [NANT-1:0] re_q;
   logic [NANT-1:0] im_q;
   logic            valid_q;

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         prev_q  <= '0;
         valid_q <= 1'b0;
      end else begin
         if (strobe_i) prev_q <= antenna_i;     // Every strobe, arming one too
         valid_q <= strobe_i && active_i;
      end
   end

   // Payload, qualified by valid
   always_ff @(posedge clk_i) begin
      if (strobe_i && active_i) begin
         re_q <= antenna_i;
         im_q <= prev_q;
      end
   end

   assign samp_o.valid = valid_q;
   assign samp_o.re    = NANT_MAX'(re_q);       // High antennas read zero
   assign samp_o.im    = NANT_MAX'(im_q);
   assign samp_o.last  = 1'b0;                  // Reserved

endmodule

// ==== hw/read_bank.sv ====
`timescale 1ns/100ps
module read_bank import corr_pkg::*; #(
   parameter type entry_t = acc_t,             // Payload of one entry
   parameter int  DEPTH   = 8
) (
   input  logic       clk_i,
   input  logic       sw_d,
   input  bank_ctl_t  bank_ctl_i,
   input  entry_t     live_i [DEPTH],          // Running counts
   input  logic [5:0] rd_idx_i,
   output entry_t     rd_o
);

   entry_t bank_q [DEPTH];                     // Last finished block

   // ----------------------------------------
   // Capture on swap, clear leaves it alone
   // ----------------------------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         for (int i = 0; i < DEPTH; i++) begin
            bank_q[i] <= '0;
         end
      end else if (bank_ctl_i.swap) begin
         for (int i = 0; i < DEPTH; i++) begin
            bank_q[i] <= live_i[i];            // Includes the wrap sample's count
         end
      end
   end

   // Indexed read, past the end reads zero
   always_comb begin
      rd_o = '0;
      for (int i = 0; i < DEPTH; i++) begin
         if (int'(rd_idx_i) == i) rd_o = bank_q[i];
      end
   end

   a_no_capture_in_clear: assert property (
      @(posedge clk_i) disable iff (sw_d) bank_ctl_i.swap |-> !bank_ctl_i.clear
   ) else $error("bank capture during clear");

endmodule

// ==== hw/vis_accum.sv ====
`timescale 1ns/100ps
module vis_accum import corr_pkg::*; #(
   parameter int NANT = 8
) (
   input  logic      clk_i,
   input  logic      sw_d,
   input  samp_t     samp_i,
   input  bank_ctl_t bank_ctl_i,
   output vis_t      vis_o [npairs(NANT)]     // Running counts, pair order
);

   // ----------------------------------------
   // One cos/sin counter pair per baseline
   // ----------------------------------------
   for (genvar ga = 0; ga < NANT; ga++) begin : g_a
      for (genvar gb = ga + 1; gb < NANT; gb++) begin : g_b
         localparam int P = pair_idx(ga, gb, NANT);

         logic cos_hit;
         logic sin_hit;

         // Agreement of one-bit samples stands in for the product
         assign cos_hit = (samp_i.re[ga] == samp_i.re[gb]);
         assign sin_hit = (samp_i.re[ga] == samp_i.im[gb]);

         always_ff @(posedge clk_i or posedge sw_d) begin
            if (sw_d) begin
               vis_o[P] <= '0;
            end else begin
               vis_o[P].cos <= acc_next(vis_o[P].cos, samp_i.valid, cos_hit, bank_ctl_i);
               vis_o[P].sin <= acc_next(vis_o[P].sin, samp_i.valid, sin_hit, bank_ctl_i);
            end
         end
      end
   end

endmodule

// ==== vlog.f ====
hw/corr_pkg.sv
hw/quad_delay.sv
hw/vis_accum.sv
hw/ones_accum.sv
hw/read_bank.sv
hw/corr_ctrl.sv
hw/corr_top.sv
bench/tb_clock.sv
bench/corr_tb.sv
